// File: flist.f
design/video_mode_pkg.sv
design/fb_bus_pkg.sv
design/fb_memory.sv
design/fb_bus_arbiter.sv
design/fb_line_reader.sv
design/fb_host_writer.sv
design/vga_pixel_stream.sv
design/vga_fb_top.sv
testbench/vga_fb_assert.sv
testbench/tb_vga_fb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_vga_fb \
  -f flist.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/Vtb_vga_fb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Testbench passed$" sim.log; then
  exit 0
fi
exit 1

// File: testbench/tb_vga_fb.sv
`timescale 1ns/1ps

module tb_vga_fb;
  import video_mode_pkg::*;
  import fb_bus_pkg::*;

  localparam int frame_slots    = h_whole_line * v_whole_frame;
  localparam int restart_slot   = v_sync_start * h_whole_line;
  localparam int num_tests      = 5;
  // 4 frames per test, 8 times over for stalls and arbitration
  localparam int timeout_cycles = num_tests * 4 * frame_slots * 8;

  typedef struct packed {
    logic     hsync;
    logic     vsync;
    logic     visible;
    fb_addr_t addr;
    pixel_t   color;
  } slot_expect_t;

  logic     clk = 1'b0;
  logic     reset;
  logic     enable;
  logic     host_we;
  fb_addr_t host_addr;
  fb_data_t host_data;
  logic     host_busy;
  logic     valid;
  logic     visible;
  logic     hsync;
  logic     vsync;
  pixel_t   color;
  fb_addr_t addr;

  fb_data_t shadow [fb_words];
  int       seed = 32'hb201;
  int       next_slot;
  int       pixels_seen;
  int       colored_pixels;
  int       checks;
  int       errors;
  int       test_errors;
  int       cycle_count;
  int       target;
  logic     writes_idle;
  logic     check_colors;

  vga_fb_top i_vga_fb_top (
    .clk      (clk),
    .reset    (reset),
    .enable   (enable),
    .host_we  (host_we),
    .host_addr(host_addr),
    .host_data(host_data),
    .host_busy(host_busy),
    .valid    (valid),
    .visible  (visible),
    .hsync    (hsync),
    .vsync    (vsync),
    .color    (color),
    .addr     (addr)
  );

  always #2 clk = ~clk;

  // expected outputs of one slot, counted from x 0, y 0
  function automatic slot_expect_t expected_slot(input int slot);
    slot_expect_t e;
    int           x;
    int           y;
    x         = slot % h_whole_line;
    y         = slot / h_whole_line;
    e.hsync   = !(x >= h_sync_start && x < h_sync_start + h_sync_pulse);
    e.vsync   = !(y >= v_sync_start && y < v_sync_start + v_sync_pulse);
    e.visible = (x < h_visible) && (y < v_visible);
    e.addr    = e.visible ? fb_addr_t'(y * h_visible + x) : '0;
    e.color   = e.visible ? pixel_t'(shadow[e.addr]) : '0;
    return e;
  endfunction

  task automatic check_pixel(input pixel_t got, input pixel_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s in slot %0d is %h, expected %h", $time, what, next_slot,
               got, exp);
    end
  endtask

  task automatic check_addr(input fb_addr_t got, input fb_addr_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s in slot %0d is %0d, expected %0d", $time, what, next_slot,
               got, exp);
    end
  endtask

  task automatic check_sync(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s in slot %0d is %b, expected %b", $time, what, next_slot,
               got, exp);
    end
  endtask

  // every valid output must be the next slot of an unstalled frame
  always @(negedge clk) begin
    slot_expect_t e;
    if (!reset) begin
      if (!writes_idle) begin
        check_colors = 1'b0;
      end
      if (valid) begin
        e = expected_slot(next_slot);
        check_sync(hsync, e.hsync, "hsync");
        check_sync(vsync, e.vsync, "vsync");
        check_sync(visible, e.visible, "visible");
        check_addr(addr, e.addr, "addr");
        if (!e.visible) begin
          check_pixel(color, '0, "blank color");
        end else if (check_colors) begin
          check_pixel(color, e.color, "color");
          colored_pixels++;
        end
        // the reader refetches from word 0 here, so colors settle if no write is open
        if (next_slot == restart_slot) begin
          check_colors = writes_idle;
        end
        next_slot = (next_slot + 1) % frame_slots;
        pixels_seen++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: stream stopped producing pixels");
      $display("Testbench failed");
      $finish;
    end
  end

  // called right after a rising edge
  task automatic write_word(input fb_addr_t a, input fb_data_t d);
    writes_idle = 1'b0;
    shadow[a]   = d;
    host_we   <= 1'b1;
    host_addr <= a;
    host_data <= d;
    @(posedge clk);
    host_we <= 1'b0;
    do begin
      @(posedge clk);
    end while (host_busy);
    writes_idle = 1'b1;
  endtask

  task automatic wait_pixels(input int count);
    int stop_at;
    stop_at = pixels_seen + count;
    while (pixels_seen < stop_at) @(posedge clk);
  endtask

  // waits for one whole frame of color checked pixels
  task automatic wait_colored_frame();
    int stop_at;
    stop_at = colored_pixels + h_visible * v_visible;
    while (colored_pixels < stop_at) @(posedge clk);
  endtask

  task automatic finish_test(input int num, input string name);
    $display("test %0d %s: %s, %0d errors", num, name,
             (errors == test_errors) ? "ok" : "FAILED", errors - test_errors);
    test_errors = errors;
  endtask

  initial begin
    reset          = 1'b1;
    enable         = 1'b0;
    host_we        = 1'b0;
    host_addr      = '0;
    host_data      = '0;
    writes_idle    = 1'b1;
    check_colors   = 1'b1;
    next_slot      = 0;
    pixels_seen    = 0;
    colored_pixels = 0;
    checks         = 0;
    errors         = 0;
    test_errors    = 0;
    cycle_count    = 0;
    for (int i = 0; i < fb_words; i++) begin
      shadow[i] = '0;
    end

    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_sync(valid, 1'b0, "valid after reset");
    check_sync(host_busy, 1'b0, "host_busy after reset");
    check_sync(i_vga_fb_top.rd_cyc, 1'b0, "reader cyc after reset");
    check_sync(i_vga_fb_top.wr_cyc, 1'b0, "writer cyc after reset");
    check_sync(i_vga_fb_top.mem_cyc, 1'b0, "memory cyc after reset");
    check_sync(i_vga_fb_top.i_fb_bus_arbiter.state == arb_idle, 1'b1, "arbiter idle");
    @(posedge clk);
    enable <= 1'b1;
    wait_pixels(1);
    finish_test(1, "reset");

    wait_pixels(2 * frame_slots);
    finish_test(2, "frame timing");

    enable <= 1'b0;
    @(posedge clk);
    for (int i = 0; i < fb_words; i++) begin
      write_word(fb_addr_t'(i), fb_data_t'($random(seed)));
    end
    enable <= 1'b1;
    wait_colored_frame();
    finish_test(3, "content");

    target = pixels_seen + 2 * frame_slots;
    while (pixels_seen < target) begin
      enable <= 1'($random(seed));
      @(posedge clk);
    end
    enable <= 1'b1;
    finish_test(4, "back-pressure");

    // start writing as the first visible pixel of a frame goes out
    while (next_slot != 1) @(posedge clk);
    for (int i = 0; i < 8; i++) begin
      write_word(fb_addr_t'($random(seed)), fb_data_t'($random(seed)));
    end
    wait_colored_frame();
    finish_test(5, "concurrent access");

    $display("tests %0d, checks %0d, errors %0d", num_tests, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: testbench/vga_fb_assert.sv
`timescale 1ns/1ps

module vga_fb_assert (
  input logic                                       clk,
  input logic                                       reset,
  input logic                                       cyc,
  input logic                                       stb,
  input logic                                       ack,
  input logic [fb_bus_pkg::prefetch_count_bits-1:0] count
);
  import fb_bus_pkg::*;

  // classic bus handshake as the memory sees it
  assert property (@(posedge clk) disable iff (reset) stb |-> cyc)
    else $error("stb high while cyc is low");

  assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
    else $error("ack held for two cycles");

  assert property (@(posedge clk) disable iff (reset) ack |-> stb)
    else $error("ack without a strobe");

  // prefetch FIFO occupancy
  assert property (@(posedge clk) disable iff (reset)
                   count <= prefetch_count_bits'(prefetch_depth))
    else $error("prefetch FIFO count above its depth");

endmodule

bind vga_fb_top vga_fb_assert i_vga_fb_assert (
  .clk  (clk),
  .reset(reset),
  .cyc  (mem_cyc),
  .stb  (mem_stb),
  .ack  (mem_ack),
  .count(i_fb_line_reader.fifo_count)
);

// File: design/vga_fb_top.sv
`timescale 1ns/1ps

module vga_fb_top (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   enable,
  input  logic                   host_we,
  input  fb_bus_pkg::fb_addr_t   host_addr,
  input  fb_bus_pkg::fb_data_t   host_data,
  output logic                   host_busy,
  output logic                   valid,
  output logic                   visible,
  output logic                   hsync,
  output logic                   vsync,
  output video_mode_pkg::pixel_t color,
  output fb_bus_pkg::fb_addr_t   addr
);
  import fb_bus_pkg::*;
  import video_mode_pkg::*;

  // stream to reader
  logic     fifo_valid;
  logic     fifo_pop;
  logic     frame_restart;
  pixel_t   fifo_data;

  // master 0
  logic     rd_cyc;
  logic     rd_stb;
  logic     rd_we;
  logic     rd_ack;
  fb_addr_t rd_adr;
  fb_data_t rd_dat_w;
  fb_data_t rd_dat_r;

  // master 1
  logic     wr_cyc;
  logic     wr_stb;
  logic     wr_we;
  logic     wr_ack;
  fb_addr_t wr_adr;
  fb_data_t wr_dat_w;

  // memory side
  logic     mem_cyc;
  logic     mem_stb;
  logic     mem_we;
  logic     mem_ack;
  fb_addr_t mem_adr;
  fb_data_t mem_dat_w;
  fb_data_t mem_dat_r;

  vga_pixel_stream i_vga_pixel_stream (
    .clk          (clk),
    .reset        (reset),
    .enable       (enable),
    .fifo_valid   (fifo_valid),
    .fifo_data    (fifo_data),
    .fifo_pop     (fifo_pop),
    .frame_restart(frame_restart),
    .valid        (valid),
    .visible      (visible),
    .hsync        (hsync),
    .vsync        (vsync),
    .color        (color),
    .addr         (addr)
  );

  fb_line_reader i_fb_line_reader (
    .clk          (clk),
    .reset        (reset),
    .frame_restart(frame_restart),
    .fifo_pop     (fifo_pop),
    .fifo_valid   (fifo_valid),
    .fifo_data    (fifo_data),
    .rd_cyc       (rd_cyc),
    .rd_stb       (rd_stb),
    .rd_we        (rd_we),
    .rd_adr       (rd_adr),
    .rd_dat_w     (rd_dat_w),
    .rd_dat_r     (rd_dat_r),
    .rd_ack       (rd_ack)
  );

  fb_host_writer i_fb_host_writer (
    .clk      (clk),
    .reset    (reset),
    .host_we  (host_we),
    .host_addr(host_addr),
    .host_data(host_data),
    .host_busy(host_busy),
    .wr_cyc   (wr_cyc),
    .wr_stb   (wr_stb),
    .wr_we    (wr_we),
    .wr_adr   (wr_adr),
    .wr_dat_w (wr_dat_w),
    .wr_ack   (wr_ack)
  );

  // the writer has no use for read data
  fb_bus_arbiter i_fb_bus_arbiter (
    .clk      (clk),
    .reset    (reset),
    .rd_cyc   (rd_cyc),
    .rd_stb   (rd_stb),
    .rd_we    (rd_we),
    .rd_adr   (rd_adr),
    .rd_dat_w (rd_dat_w),
    .rd_dat_r (rd_dat_r),
    .rd_ack   (rd_ack),
    .wr_cyc   (wr_cyc),
    .wr_stb   (wr_stb),
    .wr_we    (wr_we),
    .wr_adr   (wr_adr),
    .wr_dat_w (wr_dat_w),
    .wr_dat_r (),
    .wr_ack   (wr_ack),
    .mem_cyc  (mem_cyc),
    .mem_stb  (mem_stb),
    .mem_we   (mem_we),
    .mem_adr  (mem_adr),
    .mem_dat_w(mem_dat_w),
    .mem_dat_r(mem_dat_r),
    .mem_ack  (mem_ack)
  );

  fb_memory i_fb_memory (
    .clk  (clk),
    .reset(reset),
    .cyc  (mem_cyc),
    .stb  (mem_stb),
    .we   (mem_we),
    .adr  (mem_adr),
    .dat_w(mem_dat_w),
    .dat_r(mem_dat_r),
    .ack  (mem_ack)
  );

endmodule

// File: design/vga_pixel_stream.sv
`timescale 1ns/1ps

module vga_pixel_stream (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   enable,
  input  logic                   fifo_valid,
  input  video_mode_pkg::pixel_t fifo_data,
  output logic                   fifo_pop,
  output logic                   frame_restart,
  output logic                   valid,
  output logic                   visible,
  output logic                   hsync,
  output logic                   vsync,
  output video_mode_pkg::pixel_t color,
  output fb_bus_pkg::fb_addr_t   addr
);
  import video_mode_pkg::*;
  import fb_bus_pkg::*;

  pixel_x_t x;
  pixel_y_t y;
  logic     x_last;
  logic     y_last;
  logic     slot_visible;
  logic     hsync_slot;
  logic     vsync_slot;
  logic     advance;
  fb_addr_t slot_addr;

  assign x_last       = x == pixel_x_t'(h_whole_line - 1);
  assign y_last       = y == pixel_y_t'(v_whole_frame - 1);
  assign slot_visible = (x < pixel_x_t'(h_visible)) && (y < pixel_y_t'(v_visible));
  assign hsync_slot   = (x >= pixel_x_t'(h_sync_start)) &&
                        (x < pixel_x_t'(h_sync_start + h_sync_pulse));
  assign vsync_slot   = (y >= pixel_y_t'(v_sync_start)) &&
                        (y < pixel_y_t'(v_sync_start + v_sync_pulse));
  assign slot_addr    = fb_addr_t'(y) * fb_addr_t'(h_visible) + fb_addr_t'(x);

  // blank slots never wait on the FIFO
  assign advance  = enable && (!slot_visible || fifo_valid);
  assign fifo_pop = enable && slot_visible && fifo_valid;

  // first slot of vsync, reader starts the next frame from word 0
  assign frame_restart = advance && (x == '0) && (y == pixel_y_t'(v_sync_start));

  always_ff @(posedge clk) begin
    if (reset) begin
      x <= '0;
      y <= '0;
    end else if (advance) begin
      if (x_last) begin
        x <= '0;
        y <= y_last ? '0 : y + 1'b1;
      end else begin
        x <= x + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= 1'b0;
      hsync <= 1'b1;
      vsync <= 1'b1;
    end else begin
      valid <= advance;
      if (advance) begin
        // sync is active low
        hsync   <= !hsync_slot;
        vsync   <= !vsync_slot;
        visible <= slot_visible;
        color   <= slot_visible ? fifo_data : '0;
        addr    <= slot_visible ? slot_addr : '0;
      end
    end
  end

endmodule

// File: design/fb_host_writer.sv
`timescale 1ns/1ps

module fb_host_writer (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 host_we,
  input  fb_bus_pkg::fb_addr_t host_addr,
  input  fb_bus_pkg::fb_data_t host_data,
  output logic                 host_busy,
  output logic                 wr_cyc,
  output logic                 wr_stb,
  output logic                 wr_we,
  output fb_bus_pkg::fb_addr_t wr_adr,
  output fb_bus_pkg::fb_data_t wr_dat_w,
  input  logic                 wr_ack
);
  import fb_bus_pkg::*;

  logic     active;
  logic     accept;
  fb_addr_t req_addr;
  fb_data_t req_data;

  assign accept = host_we && !active;

  always_ff @(posedge clk) begin
    if (reset) begin
      active <= 1'b0;
    end else if (accept) begin
      active <= 1'b1;
    end else if (active && wr_ack) begin
      active <= 1'b0;
    end
  end

  // request stays stable until ack
  always_ff @(posedge clk) begin
    if (accept) begin
      req_addr <= host_addr;
      req_data <= host_data;
    end
  end

  assign host_busy = active;
  assign wr_cyc    = active;
  assign wr_stb    = active;
  assign wr_we     = active;
  assign wr_adr    = req_addr;
  assign wr_dat_w  = req_data;

endmodule

// File: design/fb_line_reader.sv
`timescale 1ns/1ps

module fb_line_reader (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   frame_restart,
  input  logic                   fifo_pop,
  output logic                   fifo_valid,
  output video_mode_pkg::pixel_t fifo_data,
  output logic                   rd_cyc,
  output logic                   rd_stb,
  output logic                   rd_we,
  output fb_bus_pkg::fb_addr_t   rd_adr,
  output fb_bus_pkg::fb_data_t   rd_dat_w,
  input  fb_bus_pkg::fb_data_t   rd_dat_r,
  input  logic                   rd_ack
);
  import fb_bus_pkg::*;
  import video_mode_pkg::*;

  fb_data_t                       fifo_mem [prefetch_depth];
  logic [prefetch_ptr_bits-1:0]   wr_ptr;
  logic [prefetch_ptr_bits-1:0]   rd_ptr;
  logic [prefetch_count_bits-1:0] fifo_count;
  // a classic bus allows one read in flight
  logic [prefetch_count_bits-1:0] in_flight;
  fb_addr_t                       fetch_addr;
  // answer of a read that was pending at restart gets dropped
  logic                           discard;
  logic                           has_room;
  logic                           start;
  logic                           push;
  logic                           pop;

  assign in_flight = prefetch_count_bits'(rd_cyc);
  assign has_room  = (fifo_count + in_flight) < prefetch_count_bits'(prefetch_depth);
  assign start     = !rd_cyc && !frame_restart && has_room;
  assign push      = rd_cyc && rd_ack && !discard && !frame_restart;
  assign pop       = fifo_pop && fifo_valid;

  assign fifo_valid = fifo_count != '0;
  assign fifo_data  = pixel_t'(fifo_mem[rd_ptr]);
  assign rd_stb     = rd_cyc;
  assign rd_we      = 1'b0;
  assign rd_dat_w   = '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_cyc     <= 1'b0;
      discard    <= 1'b0;
      fetch_addr <= '0;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fifo_count <= '0;
    end else begin
      if (rd_cyc && rd_ack) begin
        rd_cyc  <= 1'b0;
        discard <= 1'b0;
      end else if (start) begin
        rd_cyc     <= 1'b1;
        rd_adr     <= fetch_addr;
        // raster order, wraps at the end of the framebuffer
        fetch_addr <= fetch_addr + 1'b1;
      end

      if (frame_restart) begin
        fetch_addr <= '0;
        wr_ptr     <= '0;
        rd_ptr     <= '0;
        fifo_count <= '0;
        if (rd_cyc && !rd_ack) begin
          discard <= 1'b1;
        end
      end else begin
        if (push) begin
          wr_ptr <= wr_ptr + 1'b1;
        end
        if (pop) begin
          rd_ptr <= rd_ptr + 1'b1;
        end
        fifo_count <= fifo_count + prefetch_count_bits'(push) - prefetch_count_bits'(pop);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[wr_ptr] <= rd_dat_r;
    end
  end

endmodule

// File: design/fb_bus_arbiter.sv
`timescale 1ns/1ps

module fb_bus_arbiter (
  input  logic                 clk,
  input  logic                 reset,
  // master 0, line reader
  input  logic                 rd_cyc,
  input  logic                 rd_stb,
  input  logic                 rd_we,
  input  fb_bus_pkg::fb_addr_t rd_adr,
  input  fb_bus_pkg::fb_data_t rd_dat_w,
  output fb_bus_pkg::fb_data_t rd_dat_r,
  output logic                 rd_ack,
  // master 1, host writer
  input  logic                 wr_cyc,
  input  logic                 wr_stb,
  input  logic                 wr_we,
  input  fb_bus_pkg::fb_addr_t wr_adr,
  input  fb_bus_pkg::fb_data_t wr_dat_w,
  output fb_bus_pkg::fb_data_t wr_dat_r,
  output logic                 wr_ack,
  // memory slave
  output logic                 mem_cyc,
  output logic                 mem_stb,
  output logic                 mem_we,
  output fb_bus_pkg::fb_addr_t mem_adr,
  output fb_bus_pkg::fb_data_t mem_dat_w,
  input  fb_bus_pkg::fb_data_t mem_dat_r,
  input  logic                 mem_ack
);
  import fb_bus_pkg::*;

  arb_state_t state;
  // writer wins the next tie
  logic       write_first;

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= arb_idle;
      write_first <= 1'b0;
    end else begin
      case (state)
        arb_idle: begin
          if (wr_cyc && (write_first || !rd_cyc)) begin
            state       <= arb_write;
            write_first <= 1'b0;
          end else if (rd_cyc) begin
            state       <= arb_read;
            write_first <= 1'b1;
          end
        end
        // grant holds for the whole bus cycle
        arb_read: begin
          if (!rd_cyc) begin
            state <= arb_idle;
          end
        end
        arb_write: begin
          if (!wr_cyc) begin
            state <= arb_idle;
          end
        end
        default: state <= arb_idle;
      endcase
    end
  end

  always_comb begin
    mem_cyc   = 1'b0;
    mem_stb   = 1'b0;
    mem_we    = rd_we;
    mem_adr   = rd_adr;
    mem_dat_w = rd_dat_w;
    if (state == arb_read) begin
      mem_cyc = rd_cyc;
      mem_stb = rd_stb;
    end else if (state == arb_write) begin
      mem_cyc   = wr_cyc;
      mem_stb   = wr_stb;
      mem_we    = wr_we;
      mem_adr   = wr_adr;
      mem_dat_w = wr_dat_w;
    end
  end

  // only the granted master sees ack
  assign rd_ack   = (state == arb_read) && mem_ack;
  assign wr_ack   = (state == arb_write) && mem_ack;
  assign rd_dat_r = mem_dat_r;
  assign wr_dat_r = mem_dat_r;

endmodule

// File: design/fb_memory.sv
`timescale 1ns/1ps

module fb_memory (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 cyc,
  input  logic                 stb,
  input  logic                 we,
  input  fb_bus_pkg::fb_addr_t adr,
  input  fb_bus_pkg::fb_data_t dat_w,
  output fb_bus_pkg::fb_data_t dat_r,
  output logic                 ack
);
  import fb_bus_pkg::*;

  fb_data_t mem [fb_words];
  logic     request;

  // a strobe that has not been answered yet
  assign request = cyc && stb && !ack;

  always_ff @(posedge clk) begin
    if (reset) begin
      ack <= 1'b0;
      for (int i = 0; i < fb_words; i++) begin
        mem[i] <= '0;
      end
    end else begin
      ack <= request;
      if (request) begin
        if (we) begin
          mem[adr] <= dat_w;
        end
        // read data lines up with ack
        dat_r <= mem[adr];
      end
    end
  end

endmodule

// File: design/fb_bus_pkg.sv
package fb_bus_pkg;

  // one word per visible pixel, 8 by 4
  localparam int fb_addr_bits = 5;
  localparam int fb_data_bits = 12;
  localparam int fb_words     = 2 ** fb_addr_bits;

  // line reader prefetch FIFO
  localparam int prefetch_depth      = 4;
  localparam int prefetch_ptr_bits   = $clog2(prefetch_depth);
  localparam int prefetch_count_bits = $clog2(prefetch_depth + 1);

  typedef logic [fb_addr_bits-1:0] fb_addr_t;
  typedef logic [fb_data_bits-1:0] fb_data_t;

  typedef enum logic [1:0] {
    arb_idle,
    arb_read,
    arb_write
  } arb_state_t;

endpackage

// File: design/video_mode_pkg.sv
package video_mode_pkg;

  // horizontal timing, in pixel slots
  localparam int h_visible     = 8;
  localparam int h_front_porch = 2;
  localparam int h_sync_pulse  = 3;
  localparam int h_back_porch  = 3;
  localparam int h_whole_line  = h_visible + h_front_porch + h_sync_pulse + h_back_porch;

  // vertical timing, in lines
  localparam int v_visible     = 4;
  localparam int v_front_porch = 1;
  localparam int v_sync_pulse  = 2;
  localparam int v_back_porch  = 1;
  localparam int v_whole_frame = v_visible + v_front_porch + v_sync_pulse + v_back_porch;

  localparam int h_sync_start = h_visible + h_front_porch;
  localparam int v_sync_start = v_visible + v_front_porch;
  localparam int x_bits       = $clog2(h_whole_line);
  localparam int y_bits       = $clog2(v_whole_frame);

  // 4 bits each of red, green and blue
  typedef logic [11:0] pixel_t;
  typedef logic [x_bits-1:0] pixel_x_t;
  typedef logic [y_bits-1:0] pixel_y_t;

endpackage
